/* rtl/sd_reg_pkg.sv */
package sd_reg_pkg;

	// One AXI4-Lite data word and its byte lanes
	typedef logic [31:0] axil_data_t;
	typedef logic [3:0]  axil_strb_t;

	// Register word index, taken from address bits 7:2
	typedef logic [5:0]  reg_idx_t;

	// Field widths handed to the card side
	typedef logic [7:0]  clk_div_t;
	typedef logic [27:0] timeout_t;
	typedef logic [11:0] blk_size_t;
	typedef logic [15:0] blk_cnt_t;

	// Word indices of the host register map
	localparam reg_idx_t IDX_ARG2     = 6'h00;
	localparam reg_idx_t IDX_BLK      = 6'h01;
	localparam reg_idx_t IDX_ARG1     = 6'h02;
	localparam reg_idx_t IDX_CMD      = 6'h03;
	localparam reg_idx_t IDX_RESP0    = 6'h04;
	localparam reg_idx_t IDX_RESP1    = 6'h05;
	localparam reg_idx_t IDX_RESP2    = 6'h06;
	localparam reg_idx_t IDX_RESP3    = 6'h07;
	localparam reg_idx_t IDX_PSTATE   = 6'h09;
	localparam reg_idx_t IDX_HOSTCTL  = 6'h0A;
	localparam reg_idx_t IDX_CLKCTL   = 6'h0B;
	localparam reg_idx_t IDX_INTSTAT  = 6'h0C;
	localparam reg_idx_t IDX_INTSTEN  = 6'h0D;
	localparam reg_idx_t IDX_INTSIGEN = 6'h0E;
	localparam reg_idx_t IDX_CAPS     = 6'h10;
	localparam reg_idx_t IDX_VERSION  = 6'h3F;

	// Fixed read-only values
	localparam axil_data_t CAPS_VALUE    = 32'h012C32B2;
	localparam axil_data_t VERSION_VALUE = 32'h00020000;

	// Writing the upper half of the command word issues the command
	localparam axil_strb_t CMD_START_STRB = 4'hC;

	// Decoded host configuration for the card side
	typedef struct packed {
		clk_div_t  clock_divisor;
		timeout_t  data_timeout;
		logic [1:0] sw_reset;
		blk_size_t block_size;
		blk_cnt_t  block_count;
		logic      bus_width_4;
		logic      bus_width_8;
		logic      read_dir;
		logic      blk_gap_req;
	} host_cfg_t;

endpackage

/* rtl/sd_cmd_pkg.sv */
package sd_cmd_pkg;

	// Command index plus response and data flags
	typedef logic [13:0] cmd_word_t;
	// Low half of response word 0
	typedef logic [15:0] resp_low_t;

	// Interrupt sources from the command and data paths
	typedef logic [4:0]  cmd_int_t;
	typedef logic [4:0]  dat_int_t;
	// Normal and error interrupt status
	typedef logic [28:0] int_vec_t;

	// Source bits inside cmd_int_t
	localparam int INT_CMD_CC = 0;
	localparam int INT_CMD_TC = 1;

	// Bit positions in the status vector
	localparam int INT_CMD_ERR  = 16;
	localparam int INT_DAT_ERR  = 20;
	localparam int INT_AUTO_ERR = 24;
	localparam int INT_DAT_HI   = 28;

	// Auto CMD23 command word and expected card status
	localparam cmd_word_t CMD23_WORD    = 14'h171A;
	localparam resp_low_t CMD23_RESP_OK = 16'h0900;

	// Card-side levels shown in present state
	typedef struct packed {
		logic clk_stable;
		logic dat_line_act;
		logic write_active;
		logic read_active;
		logic inhibit_dat;
		logic inhibit_cmd;
	} card_state_t;

	typedef enum logic [1:0] {
		ACMD_IDLE,
		ACMD_WAIT_CC,
		ACMD_SEND
	} acmd23_state_e;

endpackage

/* rtl/sd_axil_port.sv */
module sd_axil_port import sd_reg_pkg::*; #(
	parameter int C_ADDR_WIDTH = 32
) (
	input  logic                    S_AXI_ACLK,
	input  logic                    S_AXI_ARESETN,
	// Write address and data
	input  logic [C_ADDR_WIDTH-1:0] S_AXI_AWADDR,
	input  logic                    S_AXI_AWVALID,
	output logic                    S_AXI_AWREADY,
	input  axil_data_t              S_AXI_WDATA,
	input  axil_strb_t              S_AXI_WSTRB,
	input  logic                    S_AXI_WVALID,
	output logic                    S_AXI_WREADY,
	// Write response
	output logic [1:0]              S_AXI_BRESP,
	output logic                    S_AXI_BVALID,
	input  logic                    S_AXI_BREADY,
	// Read address and data
	input  logic [C_ADDR_WIDTH-1:0] S_AXI_ARADDR,
	input  logic                    S_AXI_ARVALID,
	output logic                    S_AXI_ARREADY,
	output axil_data_t              S_AXI_RDATA,
	output logic [1:0]              S_AXI_RRESP,
	output logic                    S_AXI_RVALID,
	input  logic                    S_AXI_RREADY,
	// Register bank side
	output logic                    wr_en_o,
	output reg_idx_t                wr_idx_o,
	output axil_data_t              wr_data_o,
	output axil_strb_t              wr_strb_o,
	output logic                    rd_en_o,
	output reg_idx_t                rd_idx_o,
	input  axil_data_t              rd_data_i
);

	// Shared ready for the write address and data channels
	logic       wr_rdy_q;
	logic       bvalid_q;
	reg_idx_t   wr_idx_q;
	logic       ar_rdy_q;
	logic       rvalid_q;
	reg_idx_t   rd_idx_q;
	axil_data_t rdata_q;

	// Address and data are taken together, one write at a time
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			wr_rdy_q <= 1'b0;
			wr_idx_q <= '0;
		end else if (!wr_rdy_q && S_AXI_AWVALID && S_AXI_WVALID && !bvalid_q) begin
			wr_rdy_q <= 1'b1;
			wr_idx_q <= S_AXI_AWADDR[7:2];
		end else begin
			wr_rdy_q <= 1'b0;
		end
	end

	// Beat into the bank while both readys are up
	assign wr_en_o   = wr_rdy_q && S_AXI_AWVALID && S_AXI_WVALID;
	assign wr_idx_o  = wr_idx_q;
	// Master holds data stable until the handshake
	assign wr_data_o = S_AXI_WDATA;
	assign wr_strb_o = S_AXI_WSTRB;

	// Response follows the beat and waits for BREADY
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			bvalid_q <= 1'b0;
		end else if (wr_en_o && !bvalid_q) begin
			bvalid_q <= 1'b1;
		end else if (S_AXI_BREADY) begin
			bvalid_q <= 1'b0;
		end
	end

	// Read address accepted only with no data pending
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			ar_rdy_q <= 1'b0;
			rd_idx_q <= '0;
		end else if (!ar_rdy_q && S_AXI_ARVALID && !rvalid_q) begin
			ar_rdy_q <= 1'b1;
			rd_idx_q <= S_AXI_ARADDR[7:2];
		end else begin
			ar_rdy_q <= 1'b0;
		end
	end

	assign rd_en_o  = ar_rdy_q && S_AXI_ARVALID && !rvalid_q;
	assign rd_idx_o = rd_idx_q;

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			rvalid_q <= 1'b0;
		end else if (rd_en_o) begin
			rvalid_q <= 1'b1;
		end else if (S_AXI_RREADY) begin
			rvalid_q <= 1'b0;
		end
	end

	// Read data captured once, held until RREADY
	always_ff @(posedge S_AXI_ACLK) begin
		if (rd_en_o) begin
			rdata_q <= rd_data_i;
		end
	end

	assign S_AXI_AWREADY = wr_rdy_q;
	assign S_AXI_WREADY  = wr_rdy_q;
	assign S_AXI_BVALID  = bvalid_q;
	assign S_AXI_ARREADY = ar_rdy_q;
	assign S_AXI_RVALID  = rvalid_q;
	assign S_AXI_RDATA   = rdata_q;
	// Always OKAY
	assign S_AXI_BRESP   = 2'b00;
	assign S_AXI_RRESP   = 2'b00;

	// A response only ever follows an accepted write beat
	assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		$rose(bvalid_q) |-> $past(wr_rdy_q));

endmodule

/* rtl/sd_host_regs.sv */
module sd_host_regs import sd_reg_pkg::*, sd_cmd_pkg::*; (
	input  logic        S_AXI_ACLK,
	input  logic        S_AXI_ARESETN,
	// Write beat from the bus port
	input  logic        wr_en_i,
	input  reg_idx_t    wr_idx_i,
	input  axil_data_t  wr_data_i,
	input  axil_strb_t  wr_strb_i,
	// Read select and data
	input  reg_idx_t    rd_idx_i,
	output axil_data_t  rd_data_o,
	// Card side
	input  card_state_t card_i,
	input  axil_data_t  response0_i,
	input  axil_data_t  response1_i,
	input  axil_data_t  response2_i,
	input  axil_data_t  response3_i,
	input  cmd_int_t    cmd_int_i,
	// Interrupt status block
	input  int_vec_t    status_i,
	output logic        clr_load_o,
	output int_vec_t    clr_mask_o,
	// Decoded configuration and command
	output host_cfg_t   host_cfg_o,
	output cmd_word_t   cmd_word_o,
	output axil_data_t  arg1_o,
	output axil_data_t  arg2_o,
	output logic        cmd_start_o,
	output logic        auto_en_o
);

	axil_data_t arg2_q;
	axil_data_t blk_q;
	axil_data_t arg1_q;
	axil_data_t cmd_q;
	axil_data_t hostctl_q;
	axil_data_t clkctl_q;
	axil_data_t int_en_q;
	axil_data_t int_sig_q;
	logic       cmd_inh_q;
	axil_data_t wmask;
	axil_data_t clr_word;
	axil_data_t pstate;
	logic       start_req;

	// Expand byte strobes to a bit mask
	function automatic axil_data_t strb_mask(input axil_strb_t strb);
		axil_data_t m;
		for (int i = 0; i < 4; i++) begin
			m[i*8 +: 8] = {8{strb[i]}};
		end
		return m;
	endfunction

	// Keep unstrobed bytes of the old value
	function automatic axil_data_t merge(input axil_data_t old_v, input axil_data_t new_v,
			input axil_data_t m);
		return (old_v & ~m) | (new_v & m);
	endfunction

	assign wmask     = strb_mask(wr_strb_i);
	// Upper half written to the command word issues it
	assign start_req = wr_en_i && (wr_idx_i == IDX_CMD) && (wr_strb_i == CMD_START_STRB);

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			arg2_q      <= '0;
			blk_q       <= '0;
			arg1_q      <= '0;
			cmd_q       <= '0;
			hostctl_q   <= '0;
			clkctl_q    <= '0;
			int_en_q    <= '0;
			int_sig_q   <= '0;
			cmd_inh_q   <= 1'b0;
			cmd_start_o <= 1'b0;
		end else begin
			cmd_start_o <= start_req;
			// Software reset bits last one cycle unless written again
			clkctl_q[26:24] <= 3'b000;
			if (wr_en_i) begin
				case (wr_idx_i)
					IDX_ARG2:     arg2_q    <= merge(arg2_q, wr_data_i, wmask);
					IDX_BLK:      blk_q     <= merge(blk_q, wr_data_i, wmask);
					IDX_ARG1:     arg1_q    <= merge(arg1_q, wr_data_i, wmask);
					IDX_CMD:      cmd_q     <= merge(cmd_q, wr_data_i, wmask);
					IDX_HOSTCTL:  hostctl_q <= merge(hostctl_q, wr_data_i, wmask);
					IDX_CLKCTL:   clkctl_q  <= merge(clkctl_q, wr_data_i, wmask);
					IDX_INTSTEN:  int_en_q  <= merge(int_en_q, wr_data_i, wmask);
					IDX_INTSIGEN: int_sig_q <= merge(int_sig_q, wr_data_i, wmask);
					default: ;
				endcase
			end
			// Internal clock stable comes from the card clock generator
			clkctl_q[1] <= card_i.clk_stable;
			// Busy from issue until the command path lets go or errors out
			if (start_req) begin
				cmd_inh_q <= 1'b1;
			end else if (card_i.inhibit_cmd || (|cmd_int_i[4:2])) begin
				cmd_inh_q <= 1'b0;
			end
		end
	end

	// Status write carries a clear mask, strobed bytes only
	assign clr_word   = wr_data_i & wmask;
	assign clr_mask_o = clr_word[28:0];
	assign clr_load_o = wr_en_i && (wr_idx_i == IDX_INTSTAT);

	assign cmd_word_o = cmd_q[29:16];
	assign arg1_o     = arg1_q;
	assign arg2_o     = arg2_q;
	// Auto command field selects CMD23
	assign auto_en_o  = (cmd_q[3:2] == 2'b10);

	always_comb begin
		// Byte 1 of clock control halved
		host_cfg_o.clock_divisor = clkctl_q[15:8] >> 1;
		// 2 to the power of field plus 13 clocks
		host_cfg_o.data_timeout  = timeout_t'(1) << clkctl_q[19:16] << 13;
		// All wins over cmd, cmd over data
		host_cfg_o.sw_reset      = clkctl_q[24] ? 2'b11 :
		                           clkctl_q[25] ? 2'b01 :
		                           clkctl_q[26] ? 2'b10 : 2'b00;
		host_cfg_o.block_size    = blk_q[11:0];
		host_cfg_o.block_count   = blk_q[31:16];
		host_cfg_o.bus_width_4   = hostctl_q[1];
		host_cfg_o.bus_width_8   = hostctl_q[5];
		host_cfg_o.read_dir      = cmd_q[4];
		host_cfg_o.blk_gap_req   = hostctl_q[16];
	end

	// Present state, only command inhibit is held here
	always_comb begin
		pstate        = '0;
		pstate[0]     = cmd_inh_q;
		pstate[1]     = card_i.inhibit_dat | card_i.read_active;
		pstate[2]     = card_i.dat_line_act;
		pstate[8]     = card_i.write_active;
		pstate[9]     = card_i.read_active;
		// Card inserted, stable, detected, writable
		pstate[19:16] = 4'hF;
		// DAT[3:0] levels, high when the line is free
		pstate[23:20] = {4{~card_i.dat_line_act}};
		pstate[24]    = 1'b1;
	end

	always_comb begin
		case (rd_idx_i)
			IDX_ARG2:     rd_data_o = arg2_q;
			IDX_BLK:      rd_data_o = blk_q;
			IDX_ARG1:     rd_data_o = arg1_q;
			IDX_CMD:      rd_data_o = cmd_q;
			IDX_RESP0:    rd_data_o = response0_i;
			IDX_RESP1:    rd_data_o = response1_i;
			IDX_RESP2:    rd_data_o = response2_i;
			IDX_RESP3:    rd_data_o = response3_i;
			IDX_PSTATE:   rd_data_o = pstate;
			IDX_HOSTCTL:  rd_data_o = hostctl_q;
			IDX_CLKCTL:   rd_data_o = clkctl_q;
			// Disabled status bits read as zero
			IDX_INTSTAT:  rd_data_o = {3'b000, status_i & int_en_q[28:0]};
			IDX_INTSTEN:  rd_data_o = int_en_q;
			IDX_INTSIGEN: rd_data_o = int_sig_q;
			IDX_CAPS:     rd_data_o = CAPS_VALUE;
			IDX_VERSION:  rd_data_o = VERSION_VALUE;
			default:      rd_data_o = '0;
		endcase
	end

endmodule

/* rtl/sd_int_status.sv */
module sd_int_status import sd_cmd_pkg::*; (
	input  logic     S_AXI_ACLK,
	input  logic     S_AXI_ARESETN,
	input  cmd_int_t cmd_int_i,
	input  dat_int_t dat_int_i,
	input  logic     auto_err_i,
	input  logic     cc_mask_i,
	input  logic     clr_load_i,
	input  int_vec_t clr_mask_i,
	output int_vec_t status_o,
	output logic     cmd_int_rst_o,
	output logic     dat_int_rst_o
);

	int_vec_t clr_mask_q;
	int_vec_t src;
	logic     cc_hold_q;

	// Map the sources onto status bit positions
	always_comb begin
		src = '0;
		// CMD23 completion stays hidden, one extra cycle covers its reset
		src[0] = cmd_int_i[INT_CMD_CC] & ~(cc_mask_i | cc_hold_q);
		// Transfer complete from the command path only
		src[1] = cmd_int_i[INT_CMD_TC];
		src[INT_CMD_ERR +: 3] = cmd_int_i[4:2];
		src[INT_DAT_ERR +: 4] = dat_int_i[3:0];
		src[INT_AUTO_ERR]     = auto_err_i;
		src[INT_DAT_HI]       = dat_int_i[4];
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			clr_mask_q    <= '0;
			status_o      <= '0;
			cc_hold_q     <= 1'b0;
			cmd_int_rst_o <= 1'b0;
			dat_int_rst_o <= 1'b0;
		end else begin
			cc_hold_q <= cc_mask_i;
			// Mask stays until the sources have dropped
			if (clr_load_i) begin
				clr_mask_q <= clr_mask_i;
			end else if (!((|cmd_int_i) || (|dat_int_i))) begin
				clr_mask_q <= '0;
			end
			status_o      <= src & ~clr_mask_q;
			// Both paths drop their sources after a status write
			cmd_int_rst_o <= clr_load_i;
			dat_int_rst_o <= clr_load_i;
		end
	end

endmodule

/* rtl/sd_acmd23_seq.sv */
module sd_acmd23_seq import sd_cmd_pkg::*; (
	input  logic      S_AXI_ACLK,
	input  logic      S_AXI_ARESETN,
	input  logic      auto_en_i,
	input  logic      cmd_start_i,
	input  cmd_int_t  cmd_int_i,
	input  logic      cc_pulse_i,
	input  resp_low_t resp0_low_i,
	input  logic      err_clr_i,
	output logic      alt_sel_o,
	output logic      seq_start_o,
	output logic      seq_int_rst_o,
	output logic      auto_err_o
);

	acmd23_state_e state_q;

	// CMD23 and argument 2 go out on the start pulse and stay while it runs
	// Outside that window the command path sees the original command
	assign alt_sel_o = (state_q == ACMD_WAIT_CC) ||
	                   ((state_q == ACMD_IDLE) && auto_en_i && cmd_start_i);

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			state_q       <= ACMD_IDLE;
			seq_start_o   <= 1'b0;
			seq_int_rst_o <= 1'b0;
			auto_err_o    <= 1'b0;
		end else begin
			seq_start_o   <= 1'b0;
			seq_int_rst_o <= 1'b0;
			case (state_q)
				ACMD_IDLE: begin
					if (auto_en_i && cmd_start_i) begin
						state_q <= ACMD_WAIT_CC;
					end
				end
				ACMD_WAIT_CC: begin
					// CMD23 interrupts belong to the sequencer
					seq_int_rst_o <= |cmd_int_i;
					if (cc_pulse_i) begin
						if (resp0_low_i == CMD23_RESP_OK) begin
							// Card ready in transfer state, issue the real command
							seq_start_o <= 1'b1;
							state_q     <= ACMD_SEND;
						end else begin
							auto_err_o <= 1'b1;
							state_q    <= ACMD_IDLE;
						end
					end
				end
				ACMD_SEND: begin
					// Completion of the original command ends the sequence
					if (cc_pulse_i) begin
						state_q <= ACMD_IDLE;
					end
				end
				default: state_q <= ACMD_IDLE;
			endcase
			// Cleared by a status write
			if (err_clr_i) begin
				auto_err_o <= 1'b0;
			end
		end
	end

	// A command issued while a sequence is still running would be lost
	assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		cmd_start_i |-> (state_q == ACMD_IDLE));

endmodule

/* rtl/sd_host_axil_top.sv */
module sd_host_axil_top import sd_reg_pkg::*, sd_cmd_pkg::*; #(
	parameter int C_ADDR_WIDTH = 32
) (
	input  logic                    S_AXI_ACLK,
	input  logic                    S_AXI_ARESETN,
	input  logic [C_ADDR_WIDTH-1:0] S_AXI_AWADDR,
	input  logic                    S_AXI_AWVALID,
	output logic                    S_AXI_AWREADY,
	input  axil_data_t              S_AXI_WDATA,
	input  axil_strb_t              S_AXI_WSTRB,
	input  logic                    S_AXI_WVALID,
	output logic                    S_AXI_WREADY,
	output logic [1:0]              S_AXI_BRESP,
	output logic                    S_AXI_BVALID,
	input  logic                    S_AXI_BREADY,
	input  logic [C_ADDR_WIDTH-1:0] S_AXI_ARADDR,
	input  logic                    S_AXI_ARVALID,
	output logic                    S_AXI_ARREADY,
	output axil_data_t              S_AXI_RDATA,
	output logic [1:0]              S_AXI_RRESP,
	output logic                    S_AXI_RVALID,
	input  logic                    S_AXI_RREADY,
	// Card side
	output host_cfg_t               host_cfg_o,
	output cmd_word_t               command_o,
	output axil_data_t              argument_o,
	output logic                    cmd_start_o,
	output logic                    cmd_int_rst_o,
	output logic                    dat_int_rst_o,
	input  card_state_t             card_i,
	input  cmd_int_t                cmd_int_i,
	input  dat_int_t                dat_int_i,
	input  logic                    cc_pulse_i,
	input  axil_data_t              response0_i,
	input  axil_data_t              response1_i,
	input  axil_data_t              response2_i,
	input  axil_data_t              response3_i
);

	logic       wr_en;
	reg_idx_t   wr_idx;
	axil_data_t wr_data;
	axil_strb_t wr_strb;
	reg_idx_t   rd_idx;
	axil_data_t rd_data;
	int_vec_t   status;
	logic       clr_load;
	int_vec_t   clr_mask;
	cmd_word_t  cmd_word;
	axil_data_t arg1;
	axil_data_t arg2;
	logic       bank_start;
	logic       auto_en;
	logic       alt_sel;
	logic       seq_start;
	logic       seq_int_rst;
	logic       auto_err;
	logic       stat_cmd_rst;

	// Read strobe stays inside the port, reads have no side effects
	sd_axil_port #(
		.C_ADDR_WIDTH(C_ADDR_WIDTH)
	) sd_axil_port_i (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.S_AXI_AWADDR (S_AXI_AWADDR),
		.S_AXI_AWVALID(S_AXI_AWVALID),
		.S_AXI_AWREADY(S_AXI_AWREADY),
		.S_AXI_WDATA  (S_AXI_WDATA),
		.S_AXI_WSTRB  (S_AXI_WSTRB),
		.S_AXI_WVALID (S_AXI_WVALID),
		.S_AXI_WREADY (S_AXI_WREADY),
		.S_AXI_BRESP  (S_AXI_BRESP),
		.S_AXI_BVALID (S_AXI_BVALID),
		.S_AXI_BREADY (S_AXI_BREADY),
		.S_AXI_ARADDR (S_AXI_ARADDR),
		.S_AXI_ARVALID(S_AXI_ARVALID),
		.S_AXI_ARREADY(S_AXI_ARREADY),
		.S_AXI_RDATA  (S_AXI_RDATA),
		.S_AXI_RRESP  (S_AXI_RRESP),
		.S_AXI_RVALID (S_AXI_RVALID),
		.S_AXI_RREADY (S_AXI_RREADY),
		.wr_en_o      (wr_en),
		.wr_idx_o     (wr_idx),
		.wr_data_o    (wr_data),
		.wr_strb_o    (wr_strb),
		.rd_en_o      (),
		.rd_idx_o     (rd_idx),
		.rd_data_i    (rd_data)
	);

	sd_host_regs sd_host_regs_i (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.wr_en_i      (wr_en),
		.wr_idx_i     (wr_idx),
		.wr_data_i    (wr_data),
		.wr_strb_i    (wr_strb),
		.rd_idx_i     (rd_idx),
		.rd_data_o    (rd_data),
		.card_i       (card_i),
		.response0_i  (response0_i),
		.response1_i  (response1_i),
		.response2_i  (response2_i),
		.response3_i  (response3_i),
		.cmd_int_i    (cmd_int_i),
		.status_i     (status),
		.clr_load_o   (clr_load),
		.clr_mask_o   (clr_mask),
		.host_cfg_o   (host_cfg_o),
		.cmd_word_o   (cmd_word),
		.arg1_o       (arg1),
		.arg2_o       (arg2),
		.cmd_start_o  (bank_start),
		.auto_en_o    (auto_en)
	);

	// CMD23 completion hidden while the sequencer owns the command path
	sd_int_status sd_int_status_i (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.cmd_int_i    (cmd_int_i),
		.dat_int_i    (dat_int_i),
		.auto_err_i   (auto_err),
		.cc_mask_i    (alt_sel),
		.clr_load_i   (clr_load),
		.clr_mask_i   (clr_mask),
		.status_o     (status),
		.cmd_int_rst_o(stat_cmd_rst),
		.dat_int_rst_o(dat_int_rst_o)
	);

	// Status write pulse also clears the auto command error
	sd_acmd23_seq sd_acmd23_seq_i (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.auto_en_i    (auto_en),
		.cmd_start_i  (bank_start),
		.cmd_int_i    (cmd_int_i),
		.cc_pulse_i   (cc_pulse_i),
		.resp0_low_i  (response0_i[15:0]),
		.err_clr_i    (stat_cmd_rst),
		.alt_sel_o    (alt_sel),
		.seq_start_o  (seq_start),
		.seq_int_rst_o(seq_int_rst),
		.auto_err_o   (auto_err)
	);

	// CMD23 with argument 2 while the sequencer selects it
	assign command_o     = alt_sel ? CMD23_WORD : cmd_word;
	assign argument_o    = alt_sel ? arg2 : arg1;
	assign cmd_start_o   = bank_start | seq_start;
	assign cmd_int_rst_o = stat_cmd_rst | seq_int_rst;

endmodule

/* test/tb_sd_host.sv */
module tb_sd_host import sd_reg_pkg::*, sd_cmd_pkg::*; ();

	localparam int CLK_PERIOD      = 4;
	localparam int MAX_CASES       = 64;
	localparam int CASE_WORDS      = 5;
	localparam int CYCLES_PER_CASE = 60;
	// Card answers a command this many cycles after its start
	localparam int CC_DELAY        = 4;
	localparam int HS_LIMIT        = 50;

	logic        clk;
	logic        rst_n;
	logic [31:0] awaddr;
	logic        awvalid;
	logic        awready;
	axil_data_t  wdata;
	axil_strb_t  wstrb;
	logic        wvalid;
	logic        wready;
	logic [1:0]  bresp;
	logic        bvalid;
	logic        bready;
	logic [31:0] araddr;
	logic        arvalid;
	logic        arready;
	axil_data_t  rdata;
	logic [1:0]  rresp;
	logic        rvalid;
	logic        rready;
	host_cfg_t   host_cfg;
	cmd_word_t   command;
	axil_data_t  argument;
	logic        cmd_start;
	logic        cmd_int_rst;
	logic        dat_int_rst;
	card_state_t card;
	cmd_int_t    cmd_int;
	dat_int_t    dat_int;
	logic        cc_pulse;
	axil_data_t  response0;
	axil_data_t  response1;
	axil_data_t  response2;
	axil_data_t  response3;

	// Case memory, five words per case
	logic [31:0] case_mem [0:MAX_CASES*CASE_WORDS-1];
	int          n_cases      = 0;
	int          n_checks     = 0;
	int          n_errors     = 0;
	logic        cases_loaded = 1'b0;
	logic [31:0] lfsr_q;

	// Card model state
	int          cc_timer;
	cmd_word_t   cmd_log [$];
	axil_data_t  arg_log [$];
	int          cmd_rst_cnt  = 0;
	int          dat_rst_cnt  = 0;

	sd_host_axil_top #(
		.C_ADDR_WIDTH(32)
	) sd_host_axil_top_i (
		.S_AXI_ACLK   (clk),
		.S_AXI_ARESETN(rst_n),
		.S_AXI_AWADDR (awaddr),
		.S_AXI_AWVALID(awvalid),
		.S_AXI_AWREADY(awready),
		.S_AXI_WDATA  (wdata),
		.S_AXI_WSTRB  (wstrb),
		.S_AXI_WVALID (wvalid),
		.S_AXI_WREADY (wready),
		.S_AXI_BRESP  (bresp),
		.S_AXI_BVALID (bvalid),
		.S_AXI_BREADY (bready),
		.S_AXI_ARADDR (araddr),
		.S_AXI_ARVALID(arvalid),
		.S_AXI_ARREADY(arready),
		.S_AXI_RDATA  (rdata),
		.S_AXI_RRESP  (rresp),
		.S_AXI_RVALID (rvalid),
		.S_AXI_RREADY (rready),
		.host_cfg_o   (host_cfg),
		.command_o    (command),
		.argument_o   (argument),
		.cmd_start_o  (cmd_start),
		.cmd_int_rst_o(cmd_int_rst),
		.dat_int_rst_o(dat_int_rst),
		.card_i       (card),
		.cmd_int_i    (cmd_int),
		.dat_int_i    (dat_int),
		.cc_pulse_i   (cc_pulse),
		.response0_i  (response0),
		.response1_i  (response1),
		.response2_i  (response2),
		.response3_i  (response3)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit taken
	task automatic take_bits(input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			v      = (v << 1) | lfsr_q[0];
		end
	endtask

	task automatic compare(input axil_data_t got, input axil_data_t exp, input string what);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("[FAIL] %0t: %s, got %h, expected %h", $time, what, got, exp);
		end
	endtask

	// Card model, one completion per command start, counts reset pulses
	always @(posedge clk) begin
		if (!rst_n) begin
			cc_pulse <= 1'b0;
			cc_timer <= 0;
		end else begin
			cc_pulse <= 1'b0;
			if (cmd_start) begin
				cmd_log.push_back(command);
				arg_log.push_back(argument);
				cc_timer <= CC_DELAY;
			end else if (cc_timer > 0) begin
				cc_timer <= cc_timer - 1;
				if (cc_timer == 1) begin
					cc_pulse <= 1'b1;
				end
			end
			if (cmd_int_rst) begin
				cmd_rst_cnt++;
			end
			if (dat_int_rst) begin
				dat_rst_cnt++;
			end
		end
	end

	task automatic write_reg(input logic [31:0] addr, input axil_data_t data,
			input axil_strb_t strb);
		int n;
		int delay;
		@(posedge clk);
		awaddr  <= addr;
		awvalid <= 1'b1;
		wdata   <= data;
		wstrb   <= strb;
		wvalid  <= 1'b1;
		n = 0;
		// Both readys come up together for one cycle
		do begin
			@(posedge clk);
			n++;
		end while (!(awready && wready) && n < HS_LIMIT);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		if (!(awready && wready)) begin
			n_errors++;
			$display("Write to %h was never accepted, time %0t", addr, $time);
			return;
		end
		n = 0;
		while (!bvalid && n < HS_LIMIT) begin
			@(posedge clk);
			n++;
		end
		if (!bvalid) begin
			n_errors++;
			$display("No write response for %h, time %0t", addr, $time);
			return;
		end
		compare(bresp, 32'h0, "write response code");
		// Random BREADY back-pressure of 0 to 3 cycles
		take_bits(2, delay);
		repeat (delay) @(posedge clk);
		bready <= 1'b1;
		@(posedge clk);
		bready <= 1'b0;
	endtask

	task automatic read_reg(input logic [31:0] addr, output axil_data_t data);
		int n;
		int delay;
		data = '0;
		@(posedge clk);
		araddr  <= addr;
		arvalid <= 1'b1;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (!arready && n < HS_LIMIT);
		arvalid <= 1'b0;
		if (!arready) begin
			n_errors++;
			$display("Read of %h was never accepted, time %0t", addr, $time);
			return;
		end
		n = 0;
		while (!rvalid && n < HS_LIMIT) begin
			@(posedge clk);
			n++;
		end
		if (!rvalid) begin
			n_errors++;
			$display("No read data for %h, time %0t", addr, $time);
			return;
		end
		// RDATA holds while RVALID waits for RREADY
		data = rdata;
		compare(rresp, 32'h0, "read response code");
		take_bits(2, delay);
		repeat (delay) @(posedge clk);
		rready <= 1'b1;
		@(posedge clk);
		rready <= 1'b0;
	endtask

	// Field select for host_cfg_o checks
	function automatic axil_data_t cfg_field(input int sel);
		case (sel)
			0:       return 32'(host_cfg.clock_divisor);
			1:       return 32'(host_cfg.data_timeout);
			2:       return 32'(host_cfg.sw_reset);
			3:       return 32'(host_cfg.block_size);
			4:       return 32'(host_cfg.block_count);
			default: return '1;
		endcase
	endfunction

	// Host control bits 1, 5 and 16 and transfer mode bit 4 reach host_cfg_o
	task automatic check_mode_bits();
		// 4-bit bus only
		write_reg(32'h28, 32'h0000_0002, 4'hF);
		compare(32'(host_cfg.bus_width_4), 32'h1, "4-bit bus width set");
		compare(32'(host_cfg.bus_width_8), 32'h0, "8-bit bus width clear");
		compare(32'(host_cfg.blk_gap_req), 32'h0, "block gap request clear");
		// 8-bit bus and stop at block gap
		write_reg(32'h28, 32'h0001_0020, 4'hF);
		compare(32'(host_cfg.bus_width_4), 32'h0, "4-bit bus width clear");
		compare(32'(host_cfg.bus_width_8), 32'h1, "8-bit bus width set");
		compare(32'(host_cfg.blk_gap_req), 32'h1, "block gap request set");
		// Transfer mode half only, no command is issued
		write_reg(32'h0c, 32'h0000_0010, 4'h3);
		compare(32'(host_cfg.read_dir), 32'h1, "read direction set");
		write_reg(32'h0c, 32'h0000_0000, 4'h3);
		compare(32'(host_cfg.read_dir), 32'h0, "read direction clear");
	endtask

	task automatic run_case(input int idx);
		logic [31:0] op;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] strb;
		logic [31:0] expv;
		axil_data_t  rd;
		int          n;
		op   = case_mem[idx*CASE_WORDS];
		addr = case_mem[idx*CASE_WORDS+1];
		data = case_mem[idx*CASE_WORDS+2];
		strb = case_mem[idx*CASE_WORDS+3];
		expv = case_mem[idx*CASE_WORDS+4];
		case (op)
			32'h1: write_reg(addr, data, strb[3:0]);
			32'h2: begin
				read_reg(addr, rd);
				compare(rd, expv, $sformatf("case %0d read at %h", idx, addr[7:0]));
			end
			32'h3: compare(cfg_field(addr), expv, $sformatf("case %0d host_cfg field %0d",
				idx, addr));
			32'h4: begin
				// Source levels stay until the next case of this kind
				@(posedge clk);
				cmd_int <= data[4:0];
				dat_int <= data[12:8];
				repeat (2) @(posedge clk);
			end
			32'h5: begin
				@(posedge clk);
				response0 <= data;
			end
			32'h6: begin
				// Sequencer latency varies, wait for the logged start
				n = 0;
				while (cmd_log.size() <= int'(addr) && n < HS_LIMIT) begin
					@(negedge clk);
					n++;
				end
				if (cmd_log.size() <= int'(addr)) begin
					n_errors++;
					$display("Command start %0d never came, time %0t", addr, $time);
				end else begin
					compare(cmd_log[addr], expv, $sformatf("command of start %0d", addr));
					compare(arg_log[addr], data, $sformatf("argument of start %0d", addr));
				end
			end
			32'h7: compare(cmd_log.size(), expv, "number of command starts");
			32'h8: compare((addr == 0) ? cmd_rst_cnt : dat_rst_cnt, expv,
				$sformatf("reset pulses on path %0d", addr));
			32'h9: repeat (data) @(posedge clk);
			default: begin
				n_errors++;
				$display("Case %0d has an unknown operation %h", idx, op);
			end
		endcase
	endtask

	initial begin
		rst_n     = 1'b0;
		awaddr    = '0;
		awvalid   = 1'b0;
		wdata     = '0;
		wstrb     = '0;
		wvalid    = 1'b0;
		bready    = 1'b0;
		araddr    = '0;
		arvalid   = 1'b0;
		rready    = 1'b0;
		card      = '0;
		card.clk_stable = 1'b1;
		cmd_int   = '0;
		dat_int   = '0;
		cc_pulse  = 1'b0;
		response0 = '0;
		response1 = '0;
		response2 = '0;
		response3 = '0;
		lfsr_q    = 32'ha502;
		$readmemh("test/sd_host_cases.txt", case_mem);
		// Op zero marks the end of the list
		while (n_cases < MAX_CASES && !$isunknown(case_mem[n_cases*CASE_WORDS]) &&
				case_mem[n_cases*CASE_WORDS] != 0) begin
			n_cases++;
		end
		cases_loaded = 1'b1;
		if (n_cases == 0) begin
			n_errors++;
			$display("No cases could be read from the case file");
		end
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		compare({awready, wready, bvalid, arready, rvalid, cmd_start, cmd_int_rst, dat_int_rst},
			32'h0, "handshake and pulse outputs after reset");
		for (int i = 0; i < n_cases; i++) begin
			run_case(i);
		end
		check_mode_bits();
		repeat (4) @(posedge clk);
		$display("Cases run: %0d, checks: %0d, errors: %0d", n_cases, n_checks, n_errors);
		if (n_errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	// Budget of cycles per case plus reset and the mode bit checks
	initial begin
		wait (cases_loaded);
		#((n_cases + 2) * CYCLES_PER_CASE * CLK_PERIOD);
		$display("Watchdog expired before all %0d cases finished", n_cases);
		$display("Test failures found");
		$finish;
	end

endmodule

/* test/sd_host_cases.txt */
// op addr data strb expected (hex), op 0 ends the list
// ops 1 wr, 2 rd, 3 cfg field, 4 int sources, 5 resp0, 6 cmd log, 7 starts, 8 rst pulses, 9 idle
// Partial strobes keep the other bytes
1 00000038 11223344 f 00000000
1 00000038 aabbccdd 5 00000000
2 00000038 00000000 0 11bb33dd
1 00000028 deadbeef 2 00000000
2 00000028 00000000 0 0000be00
// Clock control decode, reset bits clear themselves, bit 1 is clock stable
1 0000002c 010a1400 f 00000000
2 0000002c 00000000 0 000a1402
3 00000000 00000000 0 0000000a
3 00000001 00000000 0 00800000
3 00000002 00000000 0 00000000
1 00000004 00200200 f 00000000
3 00000003 00000000 0 00000200
3 00000004 00000000 0 00000020
// Status follows sources and enable, status write clears and pulses resets
1 00000034 ffffffff f 00000000
4 00000000 00000105 0 00000000
2 00000030 00000000 0 00110001
1 00000034 00100001 f 00000000
2 00000030 00000000 0 00100001
1 00000034 ffffffff f 00000000
1 00000030 00000001 f 00000000
2 00000030 00000000 0 00110000
8 00000000 00000000 0 00000001
8 00000001 00000000 0 00000001
4 00000000 00000000 0 00000000
2 00000030 00000000 0 00000000
// Auto CMD23 with a good response
1 00000000 00000008 f 00000000
1 00000008 00001000 f 00000000
5 00000000 00000900 0 00000000
2 00000010 00000000 0 00000900
1 0000000c 00000008 3 00000000
1 0000000c 193a0000 c 00000000
6 00000000 00000008 0 0000171a
6 00000001 00001000 0 0000193a
9 00000000 0000000a 0 00000000
7 00000000 00000000 0 00000002
// Auto CMD23 with a bad response
5 00000000 00000b00 0 00000000
1 0000000c 193a0000 c 00000000
6 00000002 00000008 0 0000171a
9 00000000 0000000a 0 00000000
7 00000000 00000000 0 00000003
2 00000030 00000000 0 01000000
1 00000030 01000000 f 00000000
9 00000000 00000003 0 00000000
2 00000030 00000000 0 00000000
// Constants and unmapped indices
2 00000040 00000000 0 012c32b2
2 000000fc 00000000 0 00020000
2 00000020 00000000 0 00000000
2 00000044 00000000 0 00000000
0 00000000 00000000 0 00000000

/* vlog.f */
rtl/sd_reg_pkg.sv
rtl/sd_cmd_pkg.sv
rtl/sd_axil_port.sv
rtl/sd_host_regs.sv
rtl/sd_int_status.sv
rtl/sd_acmd23_seq.sv
rtl/sd_host_axil_top.sv
test/tb_sd_host.sv
